// ==== src/mulPkg.sv ====
`default_nettype none

package mulPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arithmetic widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Unsigned operands on both request lanes
    localparam int OperandWidth = 32;

    // Full product, twice the operand width
    localparam int ProductWidth = 64;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One add/shift pair per multiplier bit
    localparam int Iterations = 32;

    // Holds Iterations-1 down to zero
    localparam int CountWidth = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // LOAD pops the queue, ADD and SHIFT alternate per round,
    // DONE hands the product out for a single cycle
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ADD,
        SHIFT,
        DONE
    } mulState;

endpackage

`default_nettype wire

// ==== src/flowPkg.sv ====
`default_nettype none

package flowPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Operand pairs held; also the sender's starting credits
    localparam int QueueDepth = 4;
    localparam int QueueAddrWidth = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Results that may leave before the receiver answers
    localparam int ResultCredits = 2;
    localparam int CreditWidth = 3;

endpackage

`default_nettype wire

// ==== src/operandQueue.sv ====
`timescale 1ns/100ps
`default_nettype none

module operandQueue (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            pushValid,
    input  logic [mulPkg::OperandWidth-1:0] pushMultiplicand,
    input  logic [mulPkg::OperandWidth-1:0] pushMultiplier,
    input  logic                            opPop,
    output logic                            opValid,
    output logic [mulPkg::OperandWidth-1:0] opMultiplicand,
    output logic [mulPkg::OperandWidth-1:0] opMultiplier,
    output logic                            reqCredit
);
    import mulPkg::*;
    import flowPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [OperandWidth-1:0] multiplicandMem [QueueDepth];
    logic [OperandWidth-1:0] multiplierMem [QueueDepth];

    logic [QueueAddrWidth-1:0] writePtr;
    logic [QueueAddrWidth-1:0] readPtr;

    // One extra bit so a full queue is distinguishable from empty
    logic [QueueAddrWidth:0] occupancy;

    always_ff @(posedge clk) begin
        if (pushValid) begin
            multiplicandMem[writePtr] <= pushMultiplicand;
            multiplierMem[writePtr] <= pushMultiplier;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sender credits guarantee no push into a full queue
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            occupancy <= '0;
        end else begin
            if (pushValid) begin
                writePtr <= writePtr + 1'b1;
            end
            if (opPop) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({pushValid, opPop})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Credit goes back upstream the cycle after each pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reqCredit <= 1'b0;
        end else begin
            reqCredit <= opPop;
        end
    end

    // Head of queue
    assign opValid = (occupancy != '0);
    assign opMultiplicand = multiplicandMem[readPtr];
    assign opMultiplier = multiplierMem[readPtr];

endmodule

`default_nettype wire

// ==== src/multiplierControl.sv ====
`timescale 1ns/100ps
`default_nettype none

module multiplierControl (
    input  logic clk,
    input  logic rst,
    input  logic opValid,
    input  logic productRightmostBit,
    input  logic resCredit,
    output logic opPop,
    output logic productLoad,
    output logic productWrite,
    output logic productShiftRight,
    output logic resValid
);
    import mulPkg::*;
    import flowPkg::*;

    mulState state;
    mulState nextState;

    logic [CountWidth-1:0] roundCount;
    logic [CreditWidth-1:0] creditCount;

    logic lastRound;
    logic spendCredit;

    assign lastRound = (roundCount == '0);
    assign spendCredit = (state == DONE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                // Wait for an operand pair and somewhere to send the result
                if (opValid && (creditCount != '0)) begin
                    nextState = LOAD;
                end
            end
            LOAD: begin
                nextState = ADD;
            end
            ADD: begin
                nextState = SHIFT;
            end
            SHIFT: begin
                if (lastRound) begin
                    nextState = DONE;
                end else begin
                    nextState = ADD;
                end
            end
            DONE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Counts down; zero during the final shift
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            roundCount <= '0;
        end else if (state == LOAD) begin
            roundCount <= CountWidth'(Iterations - 1);
        end else if (state == SHIFT) begin
            roundCount <= roundCount - 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result credits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            creditCount <= CreditWidth'(ResultCredits);
        end else begin
            case ({spendCredit, resCredit})
                2'b10: creditCount <= creditCount - 1'b1;
                2'b01: creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

    // Result strobe follows DONE by one cycle, product is stable by then
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= (state == DONE);
        end
    end

    // Datapath and queue commands
    assign opPop = (state == LOAD);
    assign productLoad = (state == LOAD);
    assign productWrite = (state == ADD) && productRightmostBit;
    assign productShiftRight = (state == SHIFT);

endmodule

`default_nettype wire

// ==== src/multiplierDatapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module multiplierDatapath (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [mulPkg::OperandWidth-1:0] opMultiplicand,
    input  logic [mulPkg::OperandWidth-1:0] opMultiplier,
    input  logic                            productLoad,
    input  logic                            productWrite,
    input  logic                            productShiftRight,
    output logic                            productRightmostBit,
    output logic [mulPkg::ProductWidth-1:0] product
);
    import mulPkg::*;

    logic [OperandWidth-1:0] multiplicand;

    // Top bit holds the adder carry until the next shift
    logic [ProductWidth:0] productReg;

    logic [OperandWidth:0] upperSum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiplicand
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (productLoad) begin
            multiplicand <= opMultiplicand;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Adder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 33 bits wide so the carry lands in productReg[ProductWidth]
    assign upperSum = {1'b0, productReg[ProductWidth-1:OperandWidth]} + {1'b0, multiplicand};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Product register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            productReg <= '0;
        end else if (productLoad) begin
            // Multiplier in the low half, upper half and carry cleared
            productReg <= {{(OperandWidth + 1){1'b0}}, opMultiplier};
        end else if (productWrite) begin
            productReg[ProductWidth:OperandWidth] <= upperSum;
        end else if (productShiftRight) begin
            productReg <= productReg >> 1;
        end
    end

    assign productRightmostBit = productReg[0];
    assign product = productReg[ProductWidth-1:0];

endmodule

`default_nettype wire

// ==== src/multiplierUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module multiplierUnit (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            reqValid,
    input  logic [mulPkg::OperandWidth-1:0] reqMultiplicand,
    input  logic [mulPkg::OperandWidth-1:0] reqMultiplier,
    input  logic                            resCredit,
    output logic                            reqCredit,
    output logic                            resValid,
    output logic [mulPkg::ProductWidth-1:0] resProduct
);
    import mulPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wiring
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Queue head
    logic                    opValid;
    logic                    opPop;
    logic [OperandWidth-1:0] opMultiplicand;
    logic [OperandWidth-1:0] opMultiplier;

    // Control to datapath
    logic productLoad;
    logic productWrite;
    logic productShiftRight;
    logic productRightmostBit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    operandQueue queue (
        .clk              (clk),
        .rst              (rst),
        .pushValid        (reqValid),
        .pushMultiplicand (reqMultiplicand),
        .pushMultiplier   (reqMultiplier),
        .opPop            (opPop),
        .opValid          (opValid),
        .opMultiplicand   (opMultiplicand),
        .opMultiplier     (opMultiplier),
        .reqCredit        (reqCredit)
    );

    multiplierControl control (
        .clk                 (clk),
        .rst                 (rst),
        .opValid             (opValid),
        .productRightmostBit (productRightmostBit),
        .resCredit           (resCredit),
        .opPop               (opPop),
        .productLoad         (productLoad),
        .productWrite        (productWrite),
        .productShiftRight   (productShiftRight),
        .resValid            (resValid)
    );

    // Product output doubles as the result payload
    multiplierDatapath datapath (
        .clk                 (clk),
        .rst                 (rst),
        .opMultiplicand      (opMultiplicand),
        .opMultiplier        (opMultiplier),
        .productLoad         (productLoad),
        .productWrite        (productWrite),
        .productShiftRight   (productShiftRight),
        .productRightmostBit (productRightmostBit),
        .product             (resProduct)
    );

endmodule

`default_nettype wire

// ==== tests/multiplierTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module multiplierTb;
    import mulPkg::*;
    import flowPkg::*;

    logic                    clk;
    logic                    rst;
    logic                    reqValid;
    logic [OperandWidth-1:0] reqMultiplicand;
    logic [OperandWidth-1:0] reqMultiplier;
    logic                    resCredit;
    logic                    reqCredit;
    logic                    resValid;
    logic [ProductWidth-1:0] resProduct;

    // Pairs waiting to be sent, and the products they should give
    logic [OperandWidth-1:0] sendMultiplicand [$];
    logic [OperandWidth-1:0] sendMultiplier [$];
    logic [ProductWidth-1:0] expectedProducts [$];

    int    sendCredits;
    int    pendingReturns;
    int    reqCount;
    int    reqCreditCount;
    int    resCount;
    bit    holdCredits;
    bit    fastSend;
    int    errorCount;
    int    testErrors;
    int    passCount;
    int    failCount;
    string testName;

    multiplierUnit dut (
        .clk             (clk),
        .rst             (rst),
        .reqValid        (reqValid),
        .reqMultiplicand (reqMultiplicand),
        .reqMultiplier   (reqMultiplier),
        .resCredit       (resCredit),
        .reqCredit       (reqCredit),
        .resValid        (resValid),
        .resProduct      (resProduct)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [ProductWidth-1:0] modelProduct(
        input logic [OperandWidth-1:0] a,
        input logic [OperandWidth-1:0] b
    );
        return ProductWidth'(a) * ProductWidth'(b);
    endfunction

    task automatic checkValue(
        input string                   name,
        input logic [ProductWidth-1:0] expected,
        input logic [ProductWidth-1:0] actual
    );
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportError(input string msg);
        $display("ERROR in %s: %s", testName, msg);
        errorCount++;
        testErrors++;
    endtask

    task automatic queuePair(input logic [OperandWidth-1:0] a, input logic [OperandWidth-1:0] b);
        sendMultiplicand.push_back(a);
        sendMultiplier.push_back(b);
    endtask

    // Sample outputs at the falling edge, then drive sender and receiver
    task automatic stepCycle();
        logic [ProductWidth-1:0] expected;
        @(negedge clk);
        if (reqCredit) begin
            sendCredits++;
            reqCreditCount++;
        end
        if (resValid) begin
            resCount++;
            pendingReturns++;
            if (expectedProducts.size() == 0) begin
                reportError("a result arrived with no request outstanding");
            end else begin
                expected = expectedProducts.pop_front();
                checkValue(testName, expected, resProduct);
            end
        end
        reqValid = 1'b0;
        resCredit = 1'b0;
        if (pendingReturns > 0 && !holdCredits && ($urandom % 3) == 0) begin
            resCredit = 1'b1;
            pendingReturns--;
        end
        if (sendMultiplicand.size() > 0 && sendCredits > 0 && (fastSend || ($urandom % 4) == 0)) begin
            reqValid = 1'b1;
            reqMultiplicand = sendMultiplicand.pop_front();
            reqMultiplier = sendMultiplier.pop_front();
            expectedProducts.push_back(modelProduct(reqMultiplicand, reqMultiplier));
            sendCredits--;
            reqCount++;
        end
        if (reqCreditCount > reqCount) begin
            reportError("the queue returned more request credits than requests sent");
        end
    endtask

    task automatic drainAll(input int maxCycles);
        int cycles;
        cycles = 0;
        while ((sendMultiplicand.size() > 0 || expectedProducts.size() > 0 || pendingReturns > 0)
               && cycles < maxCycles) begin
            stepCycle();
            cycles++;
        end
        if (sendMultiplicand.size() > 0 || expectedProducts.size() > 0 || pendingReturns > 0) begin
            reportError("timed out waiting for requests, results and credits to settle");
        end
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("Test %s passed", testName);
        end else begin
            failCount++;
            $display("Test %s finished with %0d errors", testName, testErrors);
        end
        testErrors = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int startRes;
        int cycles;
        void'($urandom(2));
        clk = 1'b0;
        rst = 1'b1;
        reqValid = 1'b0;
        reqMultiplicand = '0;
        reqMultiplier = '0;
        resCredit = 1'b0;
        sendCredits = QueueDepth;
        pendingReturns = 0;
        reqCount = 0;
        reqCreditCount = 0;
        resCount = 0;
        holdCredits = 1'b0;
        fastSend = 1'b0;
        errorCount = 0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        testName = "reset state";
        checkValue(testName, '0, resProduct);
        repeat (20) begin
            stepCycle();
            checkValue(testName, 1'b0, reqCredit);
            checkValue(testName, 1'b0, resValid);
        end
        finishTest();

        testName = "corner operands";
        queuePair(32'h0000_0000, 32'h0000_0000);
        queuePair(32'h0000_0000, 32'hFFFF_FFFF);
        queuePair(32'hFFFF_FFFF, 32'h0000_0000);
        queuePair(32'h0000_0001, 32'h0000_0001);
        queuePair(32'h0000_0001, 32'hFFFF_FFFF);
        queuePair(32'hFFFF_FFFF, 32'h0000_0001);
        queuePair(32'hFFFF_FFFF, 32'hFFFF_FFFF);
        queuePair(32'h8000_0000, 32'h8000_0000);
        queuePair(32'h8000_0000, 32'hFFFF_FFFF);
        queuePair(32'h0001_0000, 32'h0001_0000);
        drainAll(4000);
        finishTest();

        testName = "random stream";
        startRes = resCount;
        fastSend = 1'b1;
        for (int i = 0; i < 200; i++) begin
            queuePair($urandom, $urandom);
        end
        drainAll(20000);
        checkValue(testName, 200, resCount - startRes);
        fastSend = 1'b0;
        finishTest();

        testName = "request credits";
        checkValue(testName, reqCount, reqCreditCount);
        checkValue(testName, QueueDepth, sendCredits);
        finishTest();

        testName = "result back-pressure";
        holdCredits = 1'b1;
        fastSend = 1'b1;
        startRes = resCount;
        for (int i = 0; i < 6; i++) begin
            queuePair($urandom, $urandom);
        end
        cycles = 0;
        while (resCount - startRes < ResultCredits && cycles < 1000) begin
            stepCycle();
            cycles++;
        end
        if (resCount - startRes < ResultCredits) begin
            reportError("results covered by the initial credits never arrived");
        end
        // Long enough for several more multiplications if credits were ignored
        repeat (300) stepCycle();
        checkValue(testName, ResultCredits, resCount - startRes);
        holdCredits = 1'b0;
        drainAll(5000);
        checkValue(testName, 6, resCount - startRes);
        fastSend = 1'b0;
        finishTest();

        $display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/mulPkg.sv
src/flowPkg.sv
src/operandQueue.sv
src/multiplierControl.sv
src/multiplierDatapath.sv
src/multiplierUnit.sv
tests/multiplierTb.sv

// ==== Bender.yml ====
package:
  name: multiplier_unit

sources:
  # Packages first, then RTL bottom-up
  - src/mulPkg.sv
  - src/flowPkg.sv
  - src/operandQueue.sv
  - src/multiplierControl.sv
  - src/multiplierDatapath.sv
  - src/multiplierUnit.sv

  - target: test
    files:
      - tests/multiplierTb.sv
